/* hw/bus_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// bus signal widths and types
////////////////////////////////////////////////////////////////////////////

package bus_pkg;

   // data bus, one word moves per beat
   localparam int WORD_BITS = 32;

   // address bus, driven by the master in the address cycle
   localparam int ADDR_BITS = 16;

   typedef logic [WORD_BITS-1:0] word_t;  // one data word on d_in / d_out
   typedef logic [ADDR_BITS-1:0] addr_t;  // one address on a_out

   // a line is WORDS words packed low word first, so word 0 sits in
   // bits [WORD_BITS-1:0] of the line ports
   // the line width depends on the WORDS module parameter and is
   // therefore built in each module from WORD_BITS

   // every transfer is a whole line, the bus carries no size field

endpackage

/* hw/ctrl_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// bus controller state and beat index
////////////////////////////////////////////////////////////////////////////

package ctrl_pkg;

   // one-hot controller state
   //   idle    waiting for a unit request or a slave select
   //   request br raised, waiting for bg
   //   master  address phase, waiting for ack_in
   //   write   master drives the line on d_out
   //   slave   selected by another master, ack_out high
   //   read    line captured from d_in (master read or slave write)
   typedef enum logic [5:0] {
      ST_IDLE    = 6'b00_0001,
      ST_REQUEST = 6'b00_0010,
      ST_MASTER  = 6'b00_0100,
      ST_WRITE   = 6'b00_1000,
      ST_SLAVE   = 6'b01_0000,
      ST_READ    = 6'b10_0000
   } state_e;

   // index of the word in flight, room for up to 8 words per line
   localparam int BEAT_BITS = 3;
   typedef logic [BEAT_BITS-1:0] beat_t;

endpackage

/* hw/beat_counter.sv */
////////////////////////////////////////////////////////////////////////////
// data beat counter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module beat_counter #(
   parameter int WORDS = 4          // words per line
) (
   input  logic             bus_clk,
   input  logic             rst_n,
   input  logic             count_start,  // data phase begins next cycle
   input  logic             count_en,     // one word moves this cycle
   output ctrl_pkg::beat_t  beat,         // word index, 0 first
   output logic             last_beat
);

   // wide enough to hold WORDS itself
   localparam int REM_BITS = $clog2(WORDS + 1);

   logic [REM_BITS-1:0] remain_q;   // words still to move

   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         remain_q <= '0;
         beat     <= '0;
      end else if (count_start) begin
         remain_q <= REM_BITS'(WORDS);
         beat     <= '0;
      end else if (count_en) begin
         remain_q <= remain_q - 1'b1;
         beat     <= beat + 1'b1;     // up while remain_q goes down
      end
   end

   // one word left, the current beat closes the line
   assign last_beat = (remain_q == REM_BITS'(1));

endmodule

/* hw/transfer_buffer.sv */
////////////////////////////////////////////////////////////////////////////
// request and line buffer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module transfer_buffer #(
   parameter int WORDS = 4          // words per line
) (
   input  logic                                bus_clk,
   input  logic                                rst_n,
   input  logic                                accept,      // latch request
   input  logic                                capture_en,  // store d_in
   input  ctrl_pkg::beat_t                     beat,
   input  bus_pkg::addr_t                      mod_a,
   input  logic [WORDS*bus_pkg::WORD_BITS-1:0] mod_write_data,
   input  bus_pkg::word_t                      d_in,
   output bus_pkg::addr_t                      a_out,
   output bus_pkg::word_t                      d_out,
   output logic [WORDS*bus_pkg::WORD_BITS-1:0] mod_read_data
);

   // index bits that address a word inside the line
   localparam int IDX_BITS = (WORDS > 1) ? $clog2(WORDS) : 1;

   bus_pkg::addr_t                  addr_q;     // request address
   bus_pkg::word_t [WORDS-1:0]      wr_line_q;  // outgoing line, word 0 low
   bus_pkg::word_t [WORDS-1:0]      rd_line_q;  // captured line
   logic           [IDX_BITS-1:0]   word_idx;

   assign word_idx = beat[IDX_BITS-1:0];

   // request latch, held until the next accepted request
   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         addr_q    <= '0;
         wr_line_q <= '0;
      end else if (accept) begin
         addr_q    <= mod_a;
         wr_line_q <= mod_write_data;
      end
   end

   // read line fills from word 0 upward, one word per capture beat
   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_line_q <= '0;
      end else if (capture_en) begin
         rd_line_q[word_idx] <= d_in;
      end
   end

   assign a_out         = addr_q;
   assign d_out         = wr_line_q[word_idx];  // word for the current beat
   assign mod_read_data = rd_line_q;            // stable until next capture

endmodule

/* hw/bus_ctrl_fsm.sv */
////////////////////////////////////////////////////////////////////////////
// bus port control FSM
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bus_ctrl_fsm (
   input  logic bus_clk,
   input  logic rst_n,
   // unit side
   input  logic mod_en,       // request pulse
   input  logic mod_wr,       // 1 = write
   // arbitration side
   input  logic bg,           // grant level
   input  logic ack_in,       // target acknowledge
   input  logic dest_in,      // selected as slave
   input  logic rw_in,        // direction from the remote master
   // datapath
   input  logic last_beat,    // final word of the line
   output logic br,
   output logic ack_out,
   output logic ctrl_oe,      // a_out / rw_out valid
   output logic d_oe,         // d_out valid
   output logic rw_out,
   output logic accept,       // latch the unit request
   output logic count_start,  // load the beat counter
   output logic count_en,     // advance the beat counter
   output logic capture_en,   // store d_in into the read line
   output logic mod_r         // done pulse to the unit
);

   ctrl_pkg::state_e state_q, state_d;

   logic wr_q;    // latched direction of our own request
   logic mst_q;   // read state belongs to a master transfer

   logic st_idle;
   logic st_req;
   logic st_mstr;
   logic st_wr;
   logic st_slv;
   logic st_rd;
   logic data_done;

   // state decode
   assign st_idle = (state_q == ctrl_pkg::ST_IDLE);
   assign st_req  = (state_q == ctrl_pkg::ST_REQUEST);
   assign st_mstr = (state_q == ctrl_pkg::ST_MASTER);
   assign st_wr   = (state_q == ctrl_pkg::ST_WRITE);
   assign st_slv  = (state_q == ctrl_pkg::ST_SLAVE);
   assign st_rd   = (state_q == ctrl_pkg::ST_READ);

   // next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         ctrl_pkg::ST_IDLE: begin
            if (dest_in)              // slave select beats a local request
               state_d = ctrl_pkg::ST_SLAVE;
            else if (mod_en)
               state_d = ctrl_pkg::ST_REQUEST;
         end
         ctrl_pkg::ST_REQUEST: begin
            if (bg)
               state_d = ctrl_pkg::ST_MASTER;
         end
         ctrl_pkg::ST_MASTER: begin
            if (ack_in)
               state_d = wr_q ? ctrl_pkg::ST_WRITE : ctrl_pkg::ST_READ;
         end
         ctrl_pkg::ST_WRITE: begin
            if (last_beat)
               state_d = ctrl_pkg::ST_IDLE;
         end
         ctrl_pkg::ST_SLAVE: begin
            // remote write brings a line in, anything else is dropped
            state_d = rw_in ? ctrl_pkg::ST_READ : ctrl_pkg::ST_IDLE;
         end
         ctrl_pkg::ST_READ: begin
            if (last_beat)
               state_d = ctrl_pkg::ST_IDLE;
         end
         default: state_d = ctrl_pkg::ST_IDLE;  // illegal code, recover
      endcase
   end

   // strobes, all decoded from the current state
   assign accept      = st_idle & mod_en & ~dest_in;
   assign br          = st_req | st_mstr | st_wr | (st_rd & mst_q);
   assign ctrl_oe     = st_mstr | st_wr | (st_rd & mst_q);
   assign rw_out      = wr_q & ctrl_oe;
   assign d_oe        = st_wr;
   assign ack_out     = st_slv;   // one cycle in the slave state
   assign count_start = (st_mstr & ack_in) | (st_slv & rw_in);
   assign count_en    = st_wr | st_rd;
   assign capture_en  = st_rd;
   assign data_done   = count_en & last_beat;

   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= ctrl_pkg::ST_IDLE;
         wr_q    <= 1'b0;
         mst_q   <= 1'b0;
         mod_r   <= 1'b0;
      end else begin
         state_q <= state_d;
         mod_r   <= data_done;    // pulse lands in idle
         if (accept) begin
            wr_q  <= mod_wr;
            mst_q <= 1'b1;
         end else if (st_idle & dest_in) begin
            mst_q <= 1'b0;        // slave role, keep br low in read
         end
      end
   end

endmodule

/* hw/bus_port_top.sv */
////////////////////////////////////////////////////////////////////////////
// bus port top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bus_port_top #(
   parameter int WORDS = 4          // words per line, 4 gives 16 bytes
) (
   input  logic                                bus_clk,
   input  logic                                rst_n,
   // unit side
   input  logic                                mod_en,
   input  logic                                mod_wr,
   input  bus_pkg::addr_t                      mod_a,
   input  logic [WORDS*bus_pkg::WORD_BITS-1:0] mod_write_data,
   output logic [WORDS*bus_pkg::WORD_BITS-1:0] mod_read_data,
   output logic                                mod_r,
   // arbitration side
   output logic                                br,
   input  logic                                bg,
   output logic                                ack_out,
   input  logic                                ack_in,
   input  logic                                dest_in,
   // bus side, split in / out / enable
   input  bus_pkg::word_t                      d_in,
   output bus_pkg::word_t                      d_out,
   output logic                                d_oe,
   output bus_pkg::addr_t                      a_out,
   output logic                                rw_out,
   input  logic                                rw_in,
   output logic                                ctrl_oe
);

   logic            accept;
   logic            count_start;
   logic            count_en;
   logic            capture_en;
   logic            last_beat;
   ctrl_pkg::beat_t beat;

   bus_ctrl_fsm u_fsm (
      .bus_clk     (bus_clk),
      .rst_n       (rst_n),
      .mod_en      (mod_en),
      .mod_wr      (mod_wr),
      .bg          (bg),
      .ack_in      (ack_in),
      .dest_in     (dest_in),
      .rw_in       (rw_in),
      .last_beat   (last_beat),
      .br          (br),
      .ack_out     (ack_out),
      .ctrl_oe     (ctrl_oe),
      .d_oe        (d_oe),
      .rw_out      (rw_out),
      .accept      (accept),
      .count_start (count_start),
      .count_en    (count_en),
      .capture_en  (capture_en),
      .mod_r       (mod_r)
   );

   // tracks which word of the line is on the bus
   beat_counter #(.WORDS(WORDS)) u_beat (
      .bus_clk     (bus_clk),
      .rst_n       (rst_n),
      .count_start (count_start),
      .count_en    (count_en),
      .beat        (beat),
      .last_beat   (last_beat)
   );

   transfer_buffer #(.WORDS(WORDS)) u_buf (
      .bus_clk        (bus_clk),
      .rst_n          (rst_n),
      .accept         (accept),
      .capture_en     (capture_en),
      .beat           (beat),
      .mod_a          (mod_a),
      .mod_write_data (mod_write_data),
      .d_in           (d_in),
      .a_out          (a_out),
      .d_out          (d_out),
      .mod_read_data  (mod_read_data)
   );

endmodule

/* sim/bus_port_tb.sv */
////////////////////////////////////////////////////////////////////////////
// bus port testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bus_port_tb;

   localparam int WORDS      = 4;
   localparam int LINE_BITS  = WORDS * bus_pkg::WORD_BITS;
   localparam int WAIT_LIMIT = 20;   // cycles any single wait may take

   typedef logic [LINE_BITS-1:0] line_t;

   logic            bus_clk;
   logic            rst_n;
   logic            mod_en;
   logic            mod_wr;
   bus_pkg::addr_t  mod_a;
   line_t           mod_write_data;
   line_t           mod_read_data;
   logic            mod_r;
   logic            br;
   logic            bg;
   logic            ack_out;
   logic            ack_in;
   logic            dest_in;
   bus_pkg::word_t  d_drive;         // other nodes driving the data wires
   bus_pkg::word_t  d_bus;
   bus_pkg::word_t  d_out;
   logic            d_oe;
   bus_pkg::addr_t  a_out;
   logic            rw_out;
   logic            rw_in;
   logic            ctrl_oe;

   integer seed;
   int     done_count;               // mod_r pulses seen so far
   int     done_expect;

   // shared data wires where the port wins while it drives
   assign d_bus = d_oe ? d_out : d_drive;

   bus_port_top #(.WORDS(WORDS)) UUT (
      .bus_clk        (bus_clk),
      .rst_n          (rst_n),
      .mod_en         (mod_en),
      .mod_wr         (mod_wr),
      .mod_a          (mod_a),
      .mod_write_data (mod_write_data),
      .mod_read_data  (mod_read_data),
      .mod_r          (mod_r),
      .br             (br),
      .bg             (bg),
      .ack_out        (ack_out),
      .ack_in         (ack_in),
      .dest_in        (dest_in),
      .d_in           (d_bus),
      .d_out          (d_out),
      .d_oe           (d_oe),
      .a_out          (a_out),
      .rw_out         (rw_out),
      .rw_in          (rw_in),
      .ctrl_oe        (ctrl_oe)
   );

   initial begin
      bus_clk = 1'b0;
      forever #50 bus_clk = ~bus_clk;   // 100 ns period
   end

   // counted on the edge that closes the pulse
   always @(posedge bus_clk) begin
      if (mod_r === 1'b1)
         done_count <= done_count + 1;
   end

   task automatic stop_run();
      $display("** FAIL **");
      $fatal(1, "stopped at first error");
   endtask

   task automatic timeout_error(input string what);
      $display("timeout at %0t: %s", $time, what);
      stop_run();
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_word(input string name, input bus_pkg::word_t got,
                             input bus_pkg::word_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_addr(input string name, input bus_pkg::addr_t got,
                             input bus_pkg::addr_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_line(input string name, input line_t got, input line_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   function automatic line_t random_line();
      line_t line;
      for (int i = 0; i < WORDS; i++)
         line[i*bus_pkg::WORD_BITS +: bus_pkg::WORD_BITS] = $random(seed);
      return line;
   endfunction

   // one-cycle mod_en pulse that returns on the edge accepting it
   task automatic send_request(input bus_pkg::addr_t addr, input logic wr,
                               input line_t line);
      @(posedge bus_clk);
      mod_en         <= 1'b1;
      mod_wr         <= wr;
      mod_a          <= addr;
      mod_write_data <= line;
      @(posedge bus_clk);
      mod_en <= 1'b0;
   endtask

   task automatic wait_request();
      int cycles;
      cycles = 0;
      @(negedge bus_clk);
      while (br !== 1'b1) begin
         if (cycles == WAIT_LIMIT)
            timeout_error("br never rose after mod_en");
         cycles++;
         @(negedge bus_clk);
      end
   endtask

   // arbiter grants after 0 to 3 idle cycles
   task automatic grant_bus(input bus_pkg::addr_t addr, input logic wr);
      int delay;
      int cycles;
      delay  = $unsigned($random(seed)) % 4;
      cycles = 0;
      repeat (delay) @(posedge bus_clk);
      @(posedge bus_clk);
      bg <= 1'b1;
      @(negedge bus_clk);
      while (ctrl_oe !== 1'b1) begin
         if (cycles == WAIT_LIMIT)
            timeout_error("ctrl_oe never rose after bg");
         cycles++;
         @(negedge bus_clk);
      end
      check_addr("a_out", a_out, addr);   // address phase
      check_bit("rw_out", rw_out, wr);
      check_bit("br", br, 1'b1);
   endtask

   // target acknowledge that returns on the edge starting the data phase
   task automatic acknowledge();
      @(posedge bus_clk);
      ack_in <= 1'b1;
      @(posedge bus_clk);
      ack_in <= 1'b0;
   endtask

   task automatic collect_write(input line_t line);
      int beats;
      beats = 0;
      @(negedge bus_clk);
      while (d_oe === 1'b1) begin
         if (beats == WORDS)
            timeout_error("d_oe stayed high past the last word");
         check_word("d_out", d_bus,
                    line[beats*bus_pkg::WORD_BITS +: bus_pkg::WORD_BITS]);
         check_bit("ctrl_oe", ctrl_oe, 1'b1);
         check_bit("rw_out", rw_out, 1'b1);
         beats++;
         @(negedge bus_clk);
      end
      check_word("write beats", bus_pkg::word_t'(beats), bus_pkg::word_t'(WORDS));
   endtask

   // model drives one word per cycle with the low word first
   task automatic drive_words(input line_t line);
      for (int i = 0; i < WORDS; i++) begin
         d_drive <= line[i*bus_pkg::WORD_BITS +: bus_pkg::WORD_BITS];
         @(negedge bus_clk);
         check_bit("ack_out", ack_out, 1'b0);
         check_bit("d_oe", d_oe, 1'b0);
         @(posedge bus_clk);
      end
      d_drive <= '0;
   endtask

   task automatic wait_done(input int expected);
      int cycles;
      cycles = 0;
      @(negedge bus_clk);
      while (done_count != expected) begin
         if (cycles == WAIT_LIMIT)
            timeout_error("mod_r done pulse never came");
         cycles++;
         @(negedge bus_clk);
      end
      repeat (3) @(negedge bus_clk);   // no second pulse may follow
      check_bit("mod_r", mod_r, 1'b0);
      check_word("mod_r pulses", bus_pkg::word_t'(done_count),
                 bus_pkg::word_t'(expected));
   endtask

   task automatic drop_grant();
      check_bit("br", br, 1'b0);
      @(posedge bus_clk);
      bg <= 1'b0;
   endtask

   // remote master selects the port through dest_in
   task automatic wait_select();
      int cycles;
      cycles = 0;
      @(negedge bus_clk);
      while (ack_out !== 1'b1) begin
         if (cycles == WAIT_LIMIT)
            timeout_error("ack_out never rose after dest_in");
         cycles++;
         @(negedge bus_clk);
      end
      check_bit("br", br, 1'b0);
   endtask

   task automatic test_reset();
      repeat (5) @(posedge bus_clk);
      rst_n <= 1'b1;
      @(negedge bus_clk);
      check_bit("br", br, 1'b0);
      check_bit("ack_out", ack_out, 1'b0);
      check_bit("ctrl_oe", ctrl_oe, 1'b0);
      check_bit("d_oe", d_oe, 1'b0);
      check_bit("mod_r", mod_r, 1'b0);
      check_line("mod_read_data", mod_read_data, '0);
   endtask

   task automatic test_master_write();
      line_t line;
      line = random_line();
      send_request(16'h1a40, 1'b1, line);
      wait_request();
      grant_bus(16'h1a40, 1'b1);
      acknowledge();
      collect_write(line);
      done_expect++;
      wait_done(done_expect);
      drop_grant();
   endtask

   task automatic test_master_read();
      line_t line;
      line = random_line();
      send_request(16'h2b80, 1'b0, '0);
      wait_request();
      grant_bus(16'h2b80, 1'b0);
      acknowledge();
      drive_words(line);
      done_expect++;
      wait_done(done_expect);
      check_line("mod_read_data", mod_read_data, line);
      drop_grant();
   endtask

   task automatic test_slave_write();
      line_t line;
      line = random_line();
      @(posedge bus_clk);
      dest_in <= 1'b1;
      rw_in   <= 1'b1;             // remote master writes into us
      wait_select();
      @(posedge bus_clk);
      dest_in <= 1'b0;
      rw_in   <= 1'b0;
      drive_words(line);
      done_expect++;
      wait_done(done_expect);
      check_line("mod_read_data", mod_read_data, line);
      // remote read is dropped after the acknowledge
      @(posedge bus_clk);
      dest_in <= 1'b1;
      rw_in   <= 1'b0;
      wait_select();
      @(posedge bus_clk);
      dest_in <= 1'b0;
      repeat (WORDS + 3) begin
         @(negedge bus_clk);
         check_bit("ack_out", ack_out, 1'b0);
         check_bit("mod_r", mod_r, 1'b0);
      end
      check_line("mod_read_data", mod_read_data, line);
      check_word("mod_r pulses", bus_pkg::word_t'(done_count),
                 bus_pkg::word_t'(done_expect));
   endtask

   task automatic test_busy_port();
      line_t first;
      line_t second;
      first  = random_line();
      second = random_line();
      send_request(16'h3c00, 1'b1, first);
      wait_request();
      @(posedge bus_clk);          // second request while waiting for bg
      mod_en         <= 1'b1;
      mod_wr         <= 1'b0;
      mod_a          <= 16'h4d20;
      mod_write_data <= second;
      @(posedge bus_clk);
      mod_en <= 1'b0;
      @(negedge bus_clk);
      check_addr("a_out", a_out, 16'h3c00);
      check_bit("ctrl_oe", ctrl_oe, 1'b0);
      grant_bus(16'h3c00, 1'b1);
      acknowledge();
      collect_write(first);        // first line and not the ignored one
      done_expect++;
      wait_done(done_expect);
      drop_grant();
   endtask

   initial begin
      seed           = 48;
      done_count     = 0;
      done_expect    = 0;
      rst_n          = 1'b0;
      mod_en         = 1'b0;
      mod_wr         = 1'b0;
      mod_a          = '0;
      mod_write_data = '0;
      bg             = 1'b0;
      ack_in         = 1'b0;
      dest_in        = 1'b0;
      rw_in          = 1'b0;
      d_drive        = '0;
      test_reset();
      test_master_write();
      test_master_read();
      test_slave_write();
      test_busy_port();
      $display("** PASS **");
      $finish;
   end

endmodule

/* filelist.f */
hw/bus_pkg.sv
hw/ctrl_pkg.sv
hw/beat_counter.sv
hw/transfer_buffer.sv
hw/bus_ctrl_fsm.sv
hw/bus_port_top.sv
sim/bus_port_tb.sv

/* Makefile */
# Verilator build and run for the bus port testbench

TOP = bus_port_tb
EXE = obj_dir/V$(TOP)
LOG = sim.log

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): filelist.f hw/*.sv sim/*.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f

# the log decides pass or fail, not the exit status of the binary
run: $(EXE)
	-./$(EXE) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
